// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dm_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/dm_buffer.sv ====
// data and program buffer words, shared between the DMI side, command results and the hart SRI port
`timescale 1ns/1ps
`default_nettype none

`include "dm_macros.svh"

module dm_buffer import dm_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rstn_i,
    dm_buf_if.buffer   bufp,
    input  wire logic  sri_en_i,
    input  wire logic  sri_we_i,
    input  sri_addr_t  sri_addr_i,
    input  logic [3:0] sri_be_i,
    input  dmi_word_t  sri_wdata_i,
    output dmi_word_t  sri_rdata_o
);

    dmi_word_t  mem_q [`DM_BUF_WORDS];

    logic       sri_in_range;
    buf_index_t sri_index;

    assign sri_in_range = sri_addr_i < sri_addr_t'(`DM_BUF_WORDS);
    assign sri_index    = buf_index_t'(sri_addr_i);

    // DMI write beats command result beats SRI
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `DM_BUF_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (bufp.we) begin
            mem_q[bufp.index] <= bufp.wdata;
        end else if (bufp.load) begin
            mem_q[0] <= bufp.load_data[31:0];
            if (bufp.load_wide) begin
                mem_q[1] <= bufp.load_data[63:32];
            end
        end else if (sri_en_i && sri_we_i && sri_in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (sri_be_i[b]) begin
                    mem_q[sri_index][b*8 +: 8] <= sri_wdata_i[b*8 +: 8];
                end
            end
        end
    end

    assign bufp.rdata   = (bufp.index < buf_index_t'(`DM_BUF_WORDS)) ? mem_q[bufp.index] : '0;
    assign bufp.op_data = {mem_q[1], mem_q[0]};

    // implicit ebreak once the hart runs off the end
    assign sri_rdata_o = sri_in_range ? mem_q[sri_index] : `DM_EBREAK;

endmodule

`default_nettype wire

// ==== hw/dm_ctrl.sv ====
// DMI request/response FSM, register decode and access-register command sequencing
`timescale 1ns/1ps
`default_nettype none

`include "dm_macros.svh"

module dm_ctrl import dm_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rstn_i,
    // DMI request
    input  wire logic  req_valid_i,
    output logic       req_ready_o,
    input  dmi_addr_t  req_addr_i,
    input  dmi_word_t  req_data_i,
    input  dmi_op_t    req_op_i,
    // DMI response
    output logic       resp_valid_o,
    input  wire logic  resp_ready_i,
    output dmi_word_t  resp_data_o,
    output dmi_op_t    resp_op_o,
    dm_reg_if.ctrl     regs,
    dm_buf_if.ctrl     bufp,
    // register file
    output logic       rf_en_o,
    output logic       rf_we_o,
    output gpr_index_t rf_regno_o,
    input  xlen_word_t rf_rdata_i,
    output xlen_word_t rf_wdata_o
);

    dm_state_t state_q;

    dmi_addr_t addr_q;
    dmi_word_t data_q;
    dmi_op_t   op_q;
    dmi_word_t resp_data_q;
    dmi_op_t   resp_op_q;

    dmi_word_t resp_data_d;
    dmi_op_t   resp_op_d;
    logic      dec_wr;      // write strobe window
    logic      is_rd;
    logic      cmd_legal;
    logic      go_xfer;
    logic      cmd_write;
    logic      cmd_wide;
    dmi_word_t abstractcs_rd;

    assign dec_wr = (state_q == ST_DECODE) && (op_q == DMI_WRITE);
    assign is_rd  = (op_q == DMI_READ);

    // access register: cmdtype 0, transfer, GPR range, 32/64 bit
    assign cmd_legal = (data_q[31:24] == 8'd0) && data_q[17]
                       && (data_q[15:0] inside {[16'h1000:16'h101f]})
                       && (data_q[22:20] inside {3'd2, 3'd3});
    assign cmd_write = data_q[16];
    assign cmd_wide  = (data_q[22:20] == 3'd3);

    // progbufsize, busy 0, relaxedpriv 0, cmderr, datacount
    assign abstractcs_rd = {3'b0, 5'(`DM_PROG_WORDS), 11'b0, 1'b0, 1'b0, regs.cmderr,
                            4'b0, 4'(`DM_DATA_WORDS)};

    assign bufp.index = (addr_q >= `DM_ADDR_PROGBUF0)
                      ? buf_index_t'(addr_q - `DM_ADDR_PROGBUF0 + `DM_DATA_WORDS)
                      : buf_index_t'(addr_q - `DM_ADDR_DATA0);
    assign bufp.wdata = data_q;
    assign regs.wdata = data_q;

    always_comb begin
        regs.wr_dmcontrol  = 1'b0;
        regs.wr_abstractcs = 1'b0;
        regs.set_cmderr    = 1'b0;
        regs.err_code      = CMDERR_NOTSUP;
        bufp.we            = 1'b0;
        resp_data_d        = '0;
        resp_op_d          = DMI_SUCCESS;
        go_xfer            = 1'b0;
        case (addr_q) inside
            [`DM_ADDR_DATA0 : (`DM_ADDR_DATA0 + `DM_DATA_WORDS - 1)],
            [`DM_ADDR_PROGBUF0 : (`DM_ADDR_PROGBUF0 + `DM_PROG_WORDS - 1)]: begin
                bufp.we = dec_wr;
                if (is_rd) resp_data_d = bufp.rdata;
            end
            `DM_ADDR_DMCONTROL: begin
                regs.wr_dmcontrol = dec_wr;
                if (is_rd) resp_data_d = regs.dmcontrol_rd;
            end
            `DM_ADDR_DMSTATUS: begin
                if (is_rd) resp_data_d = regs.dmstatus_rd;
            end
            `DM_ADDR_ABSTRACTCS: begin
                regs.wr_abstractcs = dec_wr;
                if (is_rd) resp_data_d = abstractcs_rd;
            end
            `DM_ADDR_COMMAND: begin
                // commands are dropped while an error is pending
                if (dec_wr && regs.cmderr == '0) begin
                    go_xfer         = cmd_legal;
                    regs.set_cmderr = !cmd_legal;
                end
            end
            `DM_ADDR_SBCS: begin
                if (op_q == DMI_WRITE) resp_op_d = DMI_FAILED;
            end
            default: ;
        endcase
    end

    // register file transfer, one cycle in XFER
    assign rf_en_o    = (state_q == ST_XFER) && !cmd_write;
    assign rf_we_o    = (state_q == ST_XFER) && cmd_write;
    assign rf_regno_o = data_q[4:0];  // regno 0x1000 + n maps to xn
    assign rf_wdata_o = cmd_wide ? bufp.op_data : {32'b0, bufp.op_data[31:0]};

    assign bufp.load      = rf_en_o;
    assign bufp.load_wide = cmd_wide;
    assign bufp.load_data = rf_rdata_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:   if (req_valid_i) state_q <= ST_DECODE;
                ST_DECODE: state_q <= go_xfer ? ST_XFER : ST_RESP;
                ST_XFER:   state_q <= ST_RESP;
                ST_RESP:   if (resp_ready_i) state_q <= ST_IDLE;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    // request capture and response hold
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && req_valid_i) begin
            addr_q <= req_addr_i;
            data_q <= req_data_i;
            op_q   <= req_op_i;
        end
        if (state_q == ST_DECODE) begin
            resp_data_q <= resp_data_d;
            resp_op_q   <= resp_op_d;
        end
    end

    assign req_ready_o  = (state_q == ST_IDLE);
    assign resp_valid_o = (state_q == ST_RESP);
    assign resp_data_o  = resp_data_q;
    assign resp_op_o    = resp_op_q;

endmodule

`default_nettype wire

// ==== hw/dm_ifs.sv ====
// internal bundles between the controller and the register and buffer blocks
`timescale 1ns/1ps
`default_nettype none

// controller <-> dmcontrol/abstractcs state
interface dm_reg_if import dm_pkg::*; ();
    logic      wr_dmcontrol;
    logic      wr_abstractcs;
    dmi_word_t wdata;
    logic      set_cmderr;
    cmderr_t   err_code;
    cmderr_t   cmderr;
    dmi_word_t dmcontrol_rd;
    dmi_word_t dmstatus_rd;

    modport ctrl (output wr_dmcontrol, wr_abstractcs, wdata, set_cmderr, err_code,
                  input  cmderr, dmcontrol_rd, dmstatus_rd);
    modport regs (input  wr_dmcontrol, wr_abstractcs, wdata, set_cmderr, err_code,
                  output cmderr, dmcontrol_rd, dmstatus_rd);
endinterface

// controller <-> data/progbuf storage
interface dm_buf_if import dm_pkg::*; ();
    logic       we;
    buf_index_t index;
    dmi_word_t  wdata;
    logic       load;       // command result into data0 (and data1)
    logic       load_wide;
    xlen_word_t load_data;
    dmi_word_t  rdata;
    xlen_word_t op_data;    // {data1, data0}

    modport ctrl   (output we, index, wdata, load, load_wide, load_data,
                    input  rdata, op_data);
    modport buffer (input  we, index, wdata, load, load_wide, load_data,
                    output rdata, op_data);
endinterface

`default_nettype wire

// ==== hw/dm_macros.svh ====
// debug module sizes, DMI register map and ebreak word, included by the package and RTL
`ifndef DM_MACROS_SVH
`define DM_MACROS_SVH

// hart and buffer sizing
`define DM_NUM_HARTS        4
`define DM_DATA_WORDS       2
`define DM_PROG_WORDS       4
`define DM_BUF_WORDS        (`DM_DATA_WORDS + `DM_PROG_WORDS)

// DMI register addresses (debug spec 0.13 / 1.0)
`define DM_ADDR_DATA0       7'h04
`define DM_ADDR_DMCONTROL   7'h10
`define DM_ADDR_DMSTATUS    7'h11
`define DM_ADDR_ABSTRACTCS  7'h16
`define DM_ADDR_COMMAND     7'h17
`define DM_ADDR_PROGBUF0    7'h20
`define DM_ADDR_SBCS        7'h38

// returned to the hart past the end of the buffer
`define DM_EBREAK           32'h0010_0073

`endif

// ==== hw/dm_pkg.sv ====
// shared types of the debug module, imported by its interfaces and RTL modules
`default_nettype none

`include "dm_macros.svh"

package dm_pkg;

    typedef logic [6:0]  dmi_addr_t;
    typedef logic [31:0] dmi_word_t;

    // request encodings, responses reuse the same 2-bit field
    typedef enum logic [1:0] {
        DMI_NOP   = 2'd0,
        DMI_READ  = 2'd1,
        DMI_WRITE = 2'd2
    } dmi_op_t;

    localparam dmi_op_t DMI_SUCCESS = DMI_NOP;    // op 0 on the response side
    localparam dmi_op_t DMI_FAILED  = DMI_WRITE;  // op 2 on the response side

    typedef logic [`DM_NUM_HARTS-1:0] hart_mask_t;
    typedef logic [1:0]  hart_sel_t;
    typedef logic [2:0]  buf_index_t;  // data words first, then progbuf
    typedef logic [3:0]  sri_addr_t;
    typedef logic [63:0] xlen_word_t;
    typedef logic [4:0]  gpr_index_t;
    typedef logic [2:0]  cmderr_t;

    localparam cmderr_t CMDERR_NOTSUP = 3'd2;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DECODE,
        ST_XFER,
        ST_RESP
    } dm_state_t;

endpackage

`default_nettype wire

// ==== hw/dm_regs.sv ====
// dmcontrol, dmstatus and cmderr state, written by the controller over dm_reg_if
`timescale 1ns/1ps
`default_nettype none

`include "dm_macros.svh"

module dm_regs import dm_pkg::*; (
    input  wire logic   clk_i,
    input  wire logic   rstn_i,
    dm_reg_if.regs      regs,
    input  hart_mask_t  halted_i,
    input  hart_mask_t  running_i,
    input  hart_mask_t  resume_ack_i,
    output hart_mask_t  halt_request_o,
    output hart_mask_t  resume_request_o
);

    logic       dmactive_q;
    hart_sel_t  hartsel_q;
    hart_mask_t haltreqs_q;
    hart_mask_t resumereqs_q;
    cmderr_t    cmderr_q;

    logic       sel_ok;     // written hartsel names an existing hart
    hart_sel_t  sel_nxt;
    logic       new_haltreq;

    assign sel_ok      = {regs.wdata[15:6], regs.wdata[25:16]} < 20'(`DM_NUM_HARTS);
    assign sel_nxt     = sel_ok ? hart_sel_t'(regs.wdata[17:16]) : hartsel_q;
    assign new_haltreq = regs.wdata[31];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            dmactive_q   <= 1'b0;
            hartsel_q    <= '0;
            haltreqs_q   <= '0;
            resumereqs_q <= '0;
        end else if (regs.wr_dmcontrol) begin
            dmactive_q            <= regs.wdata[0];
            hartsel_q             <= sel_nxt;
            haltreqs_q[sel_nxt]   <= new_haltreq;
            // resumereq is ignored while a halt is pending or being requested
            if (!haltreqs_q[sel_nxt] && !new_haltreq) begin
                resumereqs_q[sel_nxt] <= regs.wdata[30];
            end
        end
    end

    // sticky error, first one wins, cleared by writing 1s
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cmderr_q <= '0;
        end else if (regs.set_cmderr && cmderr_q == '0) begin
            cmderr_q <= regs.err_code;
        end else if (regs.wr_abstractcs) begin
            cmderr_q <= cmderr_q & ~regs.wdata[10:8];
        end
    end

    assign regs.cmderr = cmderr_q;

    // haltreq | resumereq(0) | 4 unused | hartsello | hartselhi | 5 unused | dmactive
    assign regs.dmcontrol_rd = {haltreqs_q[hartsel_q], 1'b0, 4'b0, 10'(hartsel_q), 10'b0,
                                5'b0, dmactive_q};

    // single selected hart, so every all/any pair is the same bit
    assign regs.dmstatus_rd = {14'b0,
                               {2{resume_ack_i[hartsel_q]}},
                               2'b0,                        // nonexistent
                               2'b0,                        // unavail
                               {2{running_i[hartsel_q]}},
                               {2{halted_i[hartsel_q]}},
                               1'b1,                        // authenticated
                               3'b0,
                               4'd3};                       // version

    assign halt_request_o   = haltreqs_q;
    assign resume_request_o = resumereqs_q;

endmodule

`default_nettype wire

// ==== hw/dm_top.sv ====
// debug module top level, joins controller, register block and buffer on plain DMI, hart, RF and SRI ports
`timescale 1ns/1ps
`default_nettype none

module dm_top import dm_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rstn_i,
    // DMI
    input  wire logic  req_valid_i,
    output logic       req_ready_o,
    input  dmi_addr_t  req_addr_i,
    input  dmi_word_t  req_data_i,
    input  dmi_op_t    req_op_i,
    output logic       resp_valid_o,
    input  wire logic  resp_ready_i,
    output dmi_word_t  resp_data_o,
    output dmi_op_t    resp_op_o,
    // hart run control
    output hart_mask_t halt_request_o,
    output hart_mask_t resume_request_o,
    input  hart_mask_t halted_i,
    input  hart_mask_t running_i,
    input  hart_mask_t resume_ack_i,
    // register file
    output logic       rf_en_o,
    output logic       rf_we_o,
    output gpr_index_t rf_regno_o,
    input  xlen_word_t rf_rdata_i,
    output xlen_word_t rf_wdata_o,
    // SRI
    input  wire logic  sri_en_i,
    input  wire logic  sri_we_i,
    input  sri_addr_t  sri_addr_i,
    input  logic [3:0] sri_be_i,
    input  dmi_word_t  sri_wdata_i,
    output dmi_word_t  sri_rdata_o
);

    dm_reg_if reg_bus ();
    dm_buf_if buf_bus ();

    dm_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_addr_i   (req_addr_i),
        .req_data_i   (req_data_i),
        .req_op_i     (req_op_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_data_o  (resp_data_o),
        .resp_op_o    (resp_op_o),
        .regs         (reg_bus.ctrl),
        .bufp         (buf_bus.ctrl),
        .rf_en_o      (rf_en_o),
        .rf_we_o      (rf_we_o),
        .rf_regno_o   (rf_regno_o),
        .rf_rdata_i   (rf_rdata_i),
        .rf_wdata_o   (rf_wdata_o)
    );

    dm_regs u_regs (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .regs             (reg_bus.regs),
        .halted_i         (halted_i),
        .running_i        (running_i),
        .resume_ack_i     (resume_ack_i),
        .halt_request_o   (halt_request_o),
        .resume_request_o (resume_request_o)
    );

    dm_buffer u_buffer (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .bufp        (buf_bus.buffer),
        .sri_en_i    (sri_en_i),
        .sri_we_i    (sri_we_i),
        .sri_addr_i  (sri_addr_i),
        .sri_be_i    (sri_be_i),
        .sri_wdata_i (sri_wdata_i),
        .sri_rdata_o (sri_rdata_o)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hw
hw/dm_pkg.sv
hw/dm_ifs.sv
hw/dm_regs.sv
hw/dm_buffer.sv
hw/dm_ctrl.sv
hw/dm_top.sv
test/dm_props.sv
test/dm_tb.sv

// ==== test/dm_props.sv ====
// DMI handshake and register file port rules, bound onto dm_top
`timescale 1ns/1ps
`default_nettype none

module dm_props import dm_pkg::*; (
    input wire logic clk_i,
    input wire logic rstn_i,
    input wire logic req_ready_o,
    input wire logic resp_valid_o,
    input wire logic resp_ready_i,
    input dmi_word_t resp_data_o,
    input dmi_op_t   resp_op_o,
    input wire logic rf_en_o,
    input wire logic rf_we_o
);

    // ready only in IDLE, valid only in RESP
    a_req_resp_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(req_ready_o && resp_valid_o))
        else $error("req_ready_o and resp_valid_o high together");

    a_rf_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(rf_en_o && rf_we_o))
        else $error("rf_en_o and rf_we_o high together");

    a_resp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (resp_valid_o && !resp_ready_i) |=>
            (resp_valid_o && $stable(resp_data_o) && $stable(resp_op_o)))
        else $error("response changed while stalled");

endmodule

bind dm_top dm_props u_props (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_data_o  (resp_data_o),
    .resp_op_o    (resp_op_o),
    .rf_en_o      (rf_en_o),
    .rf_we_o      (rf_we_o)
);

`default_nettype wire

// ==== test/dm_tb.sv ====
// testbench for dm_top, drives DMI tables, SRI and checks hart and register-file models
`timescale 1ns/1ps
`default_nettype none

`include "dm_macros.svh"

module dm_tb import dm_pkg::*;;

    localparam int TIMEOUT = 50;   // cycles per wait

    typedef struct {
        dmi_op_t   op;
        dmi_addr_t addr;
        dmi_word_t data;
        dmi_word_t exp_data;
        dmi_op_t   exp_op;
        bit        chk_data;
    } step_t;

    logic       clk_i;
    logic       rstn_i;
    logic       req_valid_i;
    logic       req_ready_o;
    dmi_addr_t  req_addr_i;
    dmi_word_t  req_data_i;
    dmi_op_t    req_op_i;
    logic       resp_valid_o;
    logic       resp_ready_i;
    dmi_word_t  resp_data_o;
    dmi_op_t    resp_op_o;
    hart_mask_t halt_request_o;
    hart_mask_t resume_request_o;
    hart_mask_t halted_i;
    hart_mask_t running_i;
    hart_mask_t resume_ack_i;
    logic       rf_en_o;
    logic       rf_we_o;
    gpr_index_t rf_regno_o;
    xlen_word_t rf_rdata_i;
    xlen_word_t rf_wdata_o;
    logic       sri_en_i;
    logic       sri_we_i;
    sri_addr_t  sri_addr_i;
    logic [3:0] sri_be_i;
    dmi_word_t  sri_wdata_i;
    dmi_word_t  sri_rdata_o;

    xlen_word_t rf_model [32];
    logic [31:0] rng_state;
    step_t      steps [$];
    int         errors;
    int         test_num;
    int         err_mark;

    dm_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // hart model, halt follows the request one cycle later
    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            halted_i     <= '0;
            resume_ack_i <= '0;
        end else begin
            halted_i     <= halt_request_o;
            resume_ack_i <= resume_request_o;   // ack held while the request stays up
        end
    end
    assign running_i = ~halted_i;

    // register file model, read data only while rf_en_o is up
    assign rf_rdata_i = rf_en_o ? rf_model[rf_regno_o] : '0;
    always @(posedge clk_i) begin
        if (rf_we_o) rf_model[rf_regno_o] <= rf_wdata_o;
    end

    function automatic dmi_word_t lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // expected dmstatus from the spec bit layout, single hart selected
    function automatic dmi_word_t status_word(logic halted, logic running, logic ack);
        dmi_word_t w;
        w = 32'h0000_0083;          // authenticated, version 3
        w[17] = ack;
        w[16] = ack;
        w[11] = running;
        w[10] = running;
        w[9]  = halted;
        w[8]  = halted;
        return w;
    endfunction

    task automatic check_word(string name, dmi_word_t got, dmi_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_op(string name, dmi_op_t got, dmi_op_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mask(string name, hart_mask_t got, hart_mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_xlen(string name, xlen_word_t got, xlen_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic timeout_fail(string what);
        $display("timeout while waiting for %s", what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic wait_req_ready();
        int n;
        n = 0;
        @(negedge clk_i);
        while (!req_ready_o) begin
            if (n >= TIMEOUT) timeout_fail("req_ready_o");
            @(negedge clk_i);
            n++;
        end
    endtask

    task automatic wait_resp_valid();
        int n;
        n = 0;
        @(negedge clk_i);
        while (!resp_valid_o) begin
            if (n >= TIMEOUT) timeout_fail("resp_valid_o");
            @(negedge clk_i);
            n++;
        end
    endtask

    task automatic issue_req(dmi_op_t op, dmi_addr_t addr, dmi_word_t data);
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_addr_i  <= addr;
        req_data_i  <= data;
        wait_req_ready();
        @(posedge clk_i);           // request accepted on this edge
        req_valid_i <= 1'b0;
    endtask

    task automatic dmi_xfer(input dmi_op_t op, input dmi_addr_t addr, input dmi_word_t data,
                            output dmi_word_t rdata, output dmi_op_t rop);
        issue_req(op, addr, data);
        wait_resp_valid();
        rdata = resp_data_o;
        rop   = resp_op_o;
        @(posedge clk_i);           // response leaves here, resp_ready_i is high
    endtask

    task automatic add_step(dmi_op_t op, dmi_addr_t addr, dmi_word_t data,
                            dmi_word_t exp_data, dmi_op_t exp_op, bit chk_data);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.exp_data = exp_data;
        s.exp_op   = exp_op;
        s.chk_data = chk_data;
        steps.push_back(s);
    endtask

    task automatic run_steps();
        dmi_word_t rdata;
        dmi_op_t   rop;
        for (int i = 0; i < steps.size(); i++) begin
            dmi_xfer(steps[i].op, steps[i].addr, steps[i].data, rdata, rop);
            check_op($sformatf("resp_op_o @%h", steps[i].addr), rop, steps[i].exp_op);
            if (steps[i].chk_data) begin
                check_word($sformatf("resp_data_o @%h", steps[i].addr), rdata,
                           steps[i].exp_data);
            end
        end
        steps.delete();
    endtask

    task automatic sri_read(input sri_addr_t addr, output dmi_word_t data);
        @(posedge clk_i);
        sri_en_i   <= 1'b1;
        sri_we_i   <= 1'b0;
        sri_addr_i <= addr;
        @(negedge clk_i);
        data = sri_rdata_o;
        @(posedge clk_i);
        sri_en_i <= 1'b0;
    endtask

    task automatic sri_write(sri_addr_t addr, logic [3:0] be, dmi_word_t wdata);
        @(posedge clk_i);
        sri_en_i    <= 1'b1;
        sri_we_i    <= 1'b1;
        sri_addr_i  <= addr;
        sri_be_i    <= be;
        sri_wdata_i <= wdata;
        @(posedge clk_i);
        sri_en_i <= 1'b0;
        sri_we_i <= 1'b0;
    endtask

    task automatic start_test();
        test_num++;
        err_mark = errors;
    endtask

    task automatic end_test(string name);
        $display("test %0d %s: %s", test_num, name, (errors == err_mark) ? "ok" : "FAILED");
    endtask

    initial begin
        dmi_word_t  buf_vals [6];
        dmi_word_t  rd;
        dmi_word_t  w;
        dmi_word_t  merged;
        dmi_op_t    rop;
        xlen_word_t x9_before;

        rstn_i       = 1'b0;
        req_valid_i  = 1'b0;
        req_addr_i   = '0;
        req_data_i   = '0;
        req_op_i     = DMI_NOP;
        resp_ready_i = 1'b1;
        sri_en_i     = 1'b0;
        sri_we_i     = 1'b0;
        sri_addr_i   = '0;
        sri_be_i     = '0;
        sri_wdata_i  = '0;
        halted_i     = '0;
        resume_ack_i = '0;
        errors       = 0;
        test_num     = 0;
        rng_state    = 32'h051e_f855;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = {lcg_next(), lcg_next()};
        end
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;

        // halt request on hart 2, out of range hartsel ignored
        start_test();
        add_step(DMI_READ, `DM_ADDR_DMSTATUS, 0, status_word(0, 1, 0), DMI_SUCCESS, 1);
        add_step(DMI_WRITE, `DM_ADDR_DMCONTROL, 32'h8002_0001, 0, DMI_SUCCESS, 0);
        add_step(DMI_READ, `DM_ADDR_DMSTATUS, 0, status_word(1, 0, 0), DMI_SUCCESS, 1);
        add_step(DMI_WRITE, `DM_ADDR_DMCONTROL, 32'h8005_0001, 0, DMI_SUCCESS, 0);
        add_step(DMI_READ, `DM_ADDR_DMCONTROL, 0, 32'h8002_0001, DMI_SUCCESS, 1);
        run_steps();
        check_mask("halt_request_o", halt_request_o, 4'b0100);
        end_test("halt request");

        // resumereq blocked while halting
        start_test();
        add_step(DMI_WRITE, `DM_ADDR_DMCONTROL, 32'hc002_0001, 0, DMI_SUCCESS, 0);
        run_steps();
        check_mask("resume_request_o", resume_request_o, 4'b0000);
        add_step(DMI_WRITE, `DM_ADDR_DMCONTROL, 32'h0002_0001, 0, DMI_SUCCESS, 0);
        add_step(DMI_WRITE, `DM_ADDR_DMCONTROL, 32'h4002_0001, 0, DMI_SUCCESS, 0);
        add_step(DMI_READ, `DM_ADDR_DMSTATUS, 0, status_word(0, 1, 1), DMI_SUCCESS, 1);
        run_steps();
        check_mask("resume_request_o", resume_request_o, 4'b0100);
        check_mask("halt_request_o", halt_request_o, 4'b0000);
        end_test("resume request");

        // buffer over DMI and SRI
        start_test();
        for (int i = 0; i < 6; i++) buf_vals[i] = lcg_next();
        add_step(DMI_WRITE, `DM_ADDR_DATA0, buf_vals[0], 0, DMI_SUCCESS, 0);
        for (int i = 0; i < 4; i++) begin
            add_step(DMI_WRITE, `DM_ADDR_PROGBUF0 + 7'(i), buf_vals[i+2], 0, DMI_SUCCESS, 0);
        end
        add_step(DMI_READ, `DM_ADDR_DATA0, 0, buf_vals[0], DMI_SUCCESS, 1);
        for (int i = 0; i < 4; i++) begin
            add_step(DMI_READ, `DM_ADDR_PROGBUF0 + 7'(i), 0, buf_vals[i+2], DMI_SUCCESS, 1);
        end
        run_steps();
        sri_read(4'd0, rd);
        check_word("sri_rdata_o @0", rd, buf_vals[0]);
        for (int i = 2; i < 6; i++) begin
            sri_read(sri_addr_t'(i), rd);
            check_word($sformatf("sri_rdata_o @%0d", i), rd, buf_vals[i]);
        end
        sri_read(4'd6, rd);
        check_word("sri_rdata_o @6", rd, 32'h0010_0073);
        sri_read(4'd15, rd);
        check_word("sri_rdata_o @15", rd, 32'h0010_0073);
        sri_write(4'd3, 4'b0101, 32'h1122_3344);
        merged = (buf_vals[3] & 32'hff00_ff00) | 32'h0022_0044;
        add_step(DMI_READ, `DM_ADDR_PROGBUF0 + 7'd1, 0, merged, DMI_SUCCESS, 1);
        add_step(DMI_READ, 7'h12, 0, 32'h0, DMI_SUCCESS, 1);
        add_step(DMI_READ, `DM_ADDR_SBCS, 0, 32'h0, DMI_SUCCESS, 1);
        add_step(DMI_WRITE, `DM_ADDR_SBCS, 32'h1, 0, DMI_FAILED, 0);
        run_steps();
        end_test("buffer round trip");

        // access register commands
        start_test();
        add_step(DMI_WRITE, `DM_ADDR_COMMAND, 32'h0032_1005, 0, DMI_SUCCESS, 0);
        add_step(DMI_READ, `DM_ADDR_DATA0, 0, rf_model[5][31:0], DMI_SUCCESS, 1);
        add_step(DMI_READ, `DM_ADDR_DATA0 + 7'd1, 0, rf_model[5][63:32], DMI_SUCCESS, 1);
        w = lcg_next();
        add_step(DMI_WRITE, `DM_ADDR_DATA0, w, 0, DMI_SUCCESS, 0);
        add_step(DMI_WRITE, `DM_ADDR_DATA0 + 7'd1, 32'hdead_beef, 0, DMI_SUCCESS, 0);
        add_step(DMI_WRITE, `DM_ADDR_COMMAND, 32'h0023_1007, 0, DMI_SUCCESS, 0);
        run_steps();
        check_xlen("rf_model x7", rf_model[7], {32'h0, w});
        end_test("register commands");

        // cmderr sticky, blocks commands until cleared
        start_test();
        x9_before = rf_model[9];
        w = lcg_next();
        add_step(DMI_WRITE, `DM_ADDR_COMMAND, 32'h0132_1005, 0, DMI_SUCCESS, 0);
        add_step(DMI_READ, `DM_ADDR_ABSTRACTCS, 0, 32'h0400_0202, DMI_SUCCESS, 1);
        add_step(DMI_WRITE, `DM_ADDR_DATA0, w, 0, DMI_SUCCESS, 0);
        add_step(DMI_WRITE, `DM_ADDR_COMMAND, 32'h0023_1009, 0, DMI_SUCCESS, 0);
        run_steps();
        check_xlen("rf_model x9", rf_model[9], x9_before);
        add_step(DMI_WRITE, `DM_ADDR_ABSTRACTCS, 32'h0000_0700, 0, DMI_SUCCESS, 0);
        add_step(DMI_READ, `DM_ADDR_ABSTRACTCS, 0, 32'h0400_0002, DMI_SUCCESS, 1);
        add_step(DMI_WRITE, `DM_ADDR_COMMAND, 32'h0022_2000, 0, DMI_SUCCESS, 0);
        add_step(DMI_READ, `DM_ADDR_ABSTRACTCS, 0, 32'h0400_0202, DMI_SUCCESS, 1);
        add_step(DMI_WRITE, `DM_ADDR_ABSTRACTCS, 32'h0000_0700, 0, DMI_SUCCESS, 0);
        add_step(DMI_WRITE, `DM_ADDR_COMMAND, 32'h0023_1009, 0, DMI_SUCCESS, 0);
        run_steps();
        check_xlen("rf_model x9", rf_model[9], {32'h0, w});
        end_test("command errors");

        // response back-pressure
        start_test();
        w = lcg_next();
        add_step(DMI_WRITE, `DM_ADDR_DATA0, w, 0, DMI_SUCCESS, 0);
        run_steps();
        @(posedge clk_i);
        resp_ready_i <= 1'b0;
        issue_req(DMI_READ, `DM_ADDR_DATA0, 0);
        wait_resp_valid();
        rd  = resp_data_o;
        rop = resp_op_o;
        check_word("resp_data_o", rd, w);
        check_op("resp_op_o", rop, DMI_SUCCESS);
        repeat (5) begin
            @(negedge clk_i);
            check_word("resp_data_o", resp_data_o, rd);
            check_op("resp_op_o", resp_op_o, rop);
            if (!resp_valid_o || req_ready_o) begin
                errors++;
                $display("response dropped or request side reopened under back-pressure");
            end
        end
        @(posedge clk_i);
        resp_ready_i <= 1'b1;
        @(posedge clk_i);
        @(negedge clk_i);
        if (resp_valid_o || !req_ready_o) begin
            errors++;
            $display("response did not complete once resp_ready_i rose");
        end
        end_test("back-pressure");

        $display("%0d tests, %0d errors", test_num, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
